// File: adc_rx_pkg.sv
package adc_rx_pkg;

  // Fixed ADC word format
  localparam int SAMPLE_W = 10;
  localparam int SLICE_W = 2;
  localparam int SLOT_CYCLES = 5;
  // Widest lane count the command word can address
  localparam int MAX_LANES = 8;
  // Frame lane idles as five ones then five zeros, MSB first
  localparam logic [SAMPLE_W-1:0] FRAME_PATTERN = 10'b11111_00000;
  localparam int REG_ADDR_W = 2;

  // Two bits of one lane in one fclk_int cycle, rise bit first
  typedef struct packed {
    logic rise;
    logic fall;
  } lane_slice_t;

  // One word slot of output, lanes above NUM_LANES read zero
  typedef struct packed {
    logic                                 valid;
    logic [MAX_LANES-1:0][SAMPLE_W-1:0]   data;
  } sample_set_t;

  // Address 0 write data, one slip pulse per set bit
  typedef struct packed {
    logic [22:0]          pad;
    logic                 frame_slip;
    logic [MAX_LANES-1:0] lane_mask;
  } slip_cmd_t;

  // Address 1 write data
  typedef struct packed {
    logic [29:0] pad;
    logic        buffer_reset;
    logic        clear_counts;
  } ctl_cmd_t;

  // Same write word, decoded by address
  typedef union packed {
    slip_cmd_t   slip;
    ctl_cmd_t    ctl;
    logic [31:0] raw;
  } reg_word_u;

  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [REG_ADDR_W-1:0] adr;
    logic [31:0]           dat;
  } bus_req_t;

  typedef struct packed {
    logic        ack;
    logic        err;
    logic [31:0] dat;
  } bus_rsp_t;

endpackage

// File: adc_lane_deser.sv
`timescale 1ns/1ps

module adc_lane_deser #(
  parameter int NUM_LANES = 4
) (
  input  logic                                            fclk_int,
  input  logic                                            rst,
  input  adc_rx_pkg::lane_slice_t [NUM_LANES-1:0]         data_slice_i,
  input  adc_rx_pkg::lane_slice_t                         frame_slice_i,
  input  logic [NUM_LANES-1:0]                            slip_lanes_i,
  input  logic                                            slip_frame_i,
  output logic [NUM_LANES-1:0][adc_rx_pkg::SAMPLE_W-1:0]  lane_words_o,
  output logic                                            word_valid_o,
  output logic                                            frame_err_o,
  output logic [3:0]                                      frame_slip_o
);

  // Data lanes plus the frame lane on top
  localparam int NCH = NUM_LANES + 1;
  localparam int HIST_W = 2 * adc_rx_pkg::SAMPLE_W;
  localparam int SW = adc_rx_pkg::SLICE_W;

  adc_rx_pkg::lane_slice_t [NCH-1:0]          slice_all;
  logic [NCH-1:0]                             slip_all;
  logic [NCH-1:0][HIST_W-1:0]                 hist;
  logic [NCH-1:0][HIST_W-1:0]                 hist_next;
  logic [NCH-1:0][3:0]                        slip;
  logic [NCH-1:0][adc_rx_pkg::SAMPLE_W-1:0]   word_next;
  logic [2:0]                                 phase;
  logic                                       slot;

  // Word starts slip bits back from the newest bit
  function automatic logic [adc_rx_pkg::SAMPLE_W-1:0] pick_word(
    input logic [HIST_W-1:0] h,
    input logic [3:0]        s
  );
    logic [HIST_W-1:0] shifted;
    shifted = h >> s;
    return shifted[adc_rx_pkg::SAMPLE_W-1:0];
  endfunction

  assign slice_all = {frame_slice_i, data_slice_i};
  assign slip_all = {slip_frame_i, slip_lanes_i};
  assign slot = (phase == 3'(adc_rx_pkg::SLOT_CYCLES - 1));
  assign frame_slip_o = slip[NUM_LANES];

  // Shift in rise then fall, extract including this edge's slice
  always_comb begin
    for (int ch = 0; ch < NCH; ch++) begin
      hist_next[ch] = {hist[ch][HIST_W-SW-1:0], slice_all[ch].rise, slice_all[ch].fall};
      word_next[ch] = pick_word(hist_next[ch], slip[ch]);
    end
  end

  always_ff @(posedge fclk_int) begin
    hist <= hist_next;
    if (slot) begin
      lane_words_o <= word_next[NUM_LANES-1:0];
    end
  end

  always_ff @(posedge fclk_int) begin
    if (rst) begin
      phase <= '0;
      slip <= '0;
      word_valid_o <= 1'b0;
      frame_err_o <= 1'b0;
    end else begin
      phase <= slot ? 3'd0 : phase + 3'd1;
      word_valid_o <= slot;
      // Misframed word counted once per slot
      frame_err_o <= slot && (word_next[NUM_LANES] != adc_rx_pkg::FRAME_PATTERN);
      for (int ch = 0; ch < NCH; ch++) begin
        if (slip_all[ch]) begin
          // Wraps modulo word width
          slip[ch] <= (slip[ch] == 4'(adc_rx_pkg::SAMPLE_W - 1)) ? 4'd0 : slip[ch] + 4'd1;
        end
      end
    end
  end

  for (genvar ch = 0; ch < NCH; ch++) begin : g_slip_chk
    a_slip_range: assert property (@(posedge fclk_int) disable iff (rst)
      slip[ch] < 4'(adc_rx_pkg::SAMPLE_W));
  end

  // One slot every SLOT_CYCLES
  a_valid_spacing: assert property (@(posedge fclk_int) disable iff (rst)
    word_valid_o |=> !word_valid_o);

endmodule

// File: adc_sample_buffer.sv
`timescale 1ns/1ps

module adc_sample_buffer #(
  parameter int NUM_LANES = 4,
  parameter int READ_DELAY = 3,
  parameter int BUF_DEPTH = 16
) (
  input  logic                                            fclk_int,
  input  logic                                            rst,
  input  logic                                            sync_i,
  input  logic                                            buffer_reset_i,
  input  logic                                            clear_counts_i,
  input  logic [NUM_LANES-1:0][adc_rx_pkg::SAMPLE_W-1:0]  lane_words_i,
  input  logic                                            word_valid_i,
  output adc_rx_pkg::sample_set_t                         samples_o,
  output logic                                            armed_o,
  output logic [31:0]                                     words_written_o
);

  localparam int PTR_W = $clog2(BUF_DEPTH);
  localparam int FILL_W = $clog2(BUF_DEPTH + 1);

  logic [NUM_LANES-1:0][adc_rx_pkg::SAMPLE_W-1:0] mem [BUF_DEPTH];
  logic [NUM_LANES-1:0][adc_rx_pkg::SAMPLE_W-1:0] rd_data;
  logic              sync_q;
  logic              sync_rise;
  logic              armed;
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [FILL_W-1:0] fill;
  logic              wr_en;
  logic              rd_en;
  logic              out_valid;
  logic [31:0]       words_cnt;

  // Same clock domain, so one register is enough for the edge
  assign sync_rise = sync_i && !sync_q;
  assign wr_en = armed && word_valid_i && !buffer_reset_i;
  // Reads start once READ_DELAY sets are waiting
  assign rd_en = wr_en && (fill == FILL_W'(READ_DELAY));
  assign armed_o = armed;
  assign words_written_o = words_cnt;

  always_ff @(posedge fclk_int) begin
    if (rst) begin
      sync_q <= 1'b0;
      armed <= 1'b0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill <= '0;
      out_valid <= 1'b0;
      words_cnt <= '0;
    end else begin
      sync_q <= sync_i;
      out_valid <= rd_en;
      if (buffer_reset_i) begin
        // Needs a fresh sync edge afterwards
        armed <= 1'b0;
        wr_ptr <= '0;
        rd_ptr <= '0;
        fill <= '0;
      end else begin
        if (sync_rise) begin
          armed <= 1'b1;
        end
        if (wr_en) begin
          wr_ptr <= wr_ptr + 1'b1;
        end
        if (rd_en) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
        // Fill freezes at READ_DELAY once reading
        if (wr_en && !rd_en) begin
          fill <= fill + 1'b1;
        end
      end
      if (clear_counts_i) begin
        words_cnt <= '0;
      end else if (wr_en) begin
        words_cnt <= words_cnt + 32'd1;
      end
    end
  end

  always_ff @(posedge fclk_int) begin
    if (wr_en) begin
      mem[wr_ptr] <= lane_words_i;
    end
    if (rd_en) begin
      rd_data <= mem[rd_ptr];
    end
  end

  always_comb begin
    samples_o = '0;
    samples_o.valid = out_valid;
    samples_o.data[NUM_LANES-1:0] = rd_data;
  end

  a_fill_bound: assert property (@(posedge fclk_int) disable iff (rst)
    fill <= FILL_W'(BUF_DEPTH));

  // Output valid only follows a read taken while armed
  a_read_armed: assert property (@(posedge fclk_int) disable iff (rst)
    samples_o.valid |-> $past(armed));

endmodule

// File: adc_rx_regs.sv
`timescale 1ns/1ps

module adc_rx_regs #(
  parameter int NUM_LANES = 4
) (
  input  logic                     fclk_int,
  input  logic                     rst,
  input  adc_rx_pkg::bus_req_t     bus_req_i,
  input  logic                     frame_err_i,
  input  logic [31:0]              words_written_i,
  input  logic [3:0]               frame_slip_i,
  input  logic                     armed_i,
  output adc_rx_pkg::bus_rsp_t     bus_rsp_o,
  output logic [NUM_LANES-1:0]     slip_lanes_o,
  output logic                     slip_frame_o,
  output logic                     clear_counts_o,
  output logic                     buffer_reset_o
);

  adc_rx_pkg::reg_word_u wdata;
  logic        req_take;
  logic        wr_slip;
  logic        wr_ctl;
  logic        bad_req;
  logic [31:0] rd_mux;
  logic [31:0] frame_err_cnt;

  // Hold off while this request's response is still on the bus
  assign req_take = bus_req_i.cyc && bus_req_i.stb && !bus_rsp_o.ack && !bus_rsp_o.err;
  assign wdata.raw = bus_req_i.dat;
  assign wr_slip = req_take && bus_req_i.we && (bus_req_i.adr == 2'd0);
  assign wr_ctl = req_take && bus_req_i.we && (bus_req_i.adr == 2'd1);
  // Address 0 write only, the rest read only apart from the ctl word
  assign bad_req = bus_req_i.we ? (bus_req_i.adr > 2'd1) : (bus_req_i.adr == 2'd0);

  always_comb begin
    case (bus_req_i.adr)
      2'd1: rd_mux = frame_err_cnt;
      2'd2: rd_mux = words_written_i;
      2'd3: rd_mux = {23'd0, armed_i, 4'd0, frame_slip_i};
      default: rd_mux = '0;
    endcase
  end

  always_ff @(posedge fclk_int) begin
    if (rst) begin
      bus_rsp_o <= '0;
      slip_lanes_o <= '0;
      slip_frame_o <= 1'b0;
      clear_counts_o <= 1'b0;
      buffer_reset_o <= 1'b0;
    end else begin
      bus_rsp_o.ack <= req_take && !bad_req;
      bus_rsp_o.err <= req_take && bad_req;
      if (req_take) begin
        bus_rsp_o.dat <= bus_req_i.we ? 32'd0 : rd_mux;
      end
      // Strobes land with the response
      slip_lanes_o <= wr_slip ? wdata.slip.lane_mask[NUM_LANES-1:0] : '0;
      slip_frame_o <= wr_slip && wdata.slip.frame_slip;
      clear_counts_o <= wr_ctl && wdata.ctl.clear_counts;
      buffer_reset_o <= wr_ctl && wdata.ctl.buffer_reset;
    end
  end

  // Misframed words since last clear
  always_ff @(posedge fclk_int) begin
    if (rst) begin
      frame_err_cnt <= '0;
    end else if (clear_counts_o) begin
      frame_err_cnt <= '0;
    end else if (frame_err_i) begin
      frame_err_cnt <= frame_err_cnt + 32'd1;
    end
  end

  // Exactly one kind of response, and only for a taken request
  a_one_rsp: assert property (@(posedge fclk_int) disable iff (rst)
    (bus_rsp_o.ack || bus_rsp_o.err) |-> !(bus_rsp_o.ack && bus_rsp_o.err) && $past(req_take));

endmodule

// File: adc_rx_top.sv
`timescale 1ns/1ps

module adc_rx_top #(
  parameter int NUM_LANES = 4,
  parameter int READ_DELAY = 3,
  parameter int BUF_DEPTH = 16
) (
  input  logic                                     fclk_int,
  input  logic                                     rst,
  input  adc_rx_pkg::lane_slice_t [NUM_LANES-1:0]  data_slice_i,
  input  adc_rx_pkg::lane_slice_t                  frame_slice_i,
  input  logic                                     sync_i,
  input  adc_rx_pkg::bus_req_t                     bus_req_i,
  output adc_rx_pkg::sample_set_t                  samples_o,
  output adc_rx_pkg::bus_rsp_t                     bus_rsp_o
);

  // Deserializer outputs
  logic [NUM_LANES-1:0][adc_rx_pkg::SAMPLE_W-1:0] lane_words;
  logic                 word_valid;
  logic                 frame_err;
  logic [3:0]           frame_slip;
  // Register strobes
  logic [NUM_LANES-1:0] slip_lanes;
  logic                 slip_frame;
  logic                 clear_counts;
  logic                 buffer_reset;
  // Buffer status
  logic                 armed;
  logic [31:0]          words_written;

  adc_lane_deser #(
    .NUM_LANES(NUM_LANES)
  ) adc_lane_deser_inst (
    .fclk_int(fclk_int),
    .rst(rst),
    .data_slice_i(data_slice_i),
    .frame_slice_i(frame_slice_i),
    .slip_lanes_i(slip_lanes),
    .slip_frame_i(slip_frame),
    .lane_words_o(lane_words),
    .word_valid_o(word_valid),
    .frame_err_o(frame_err),
    .frame_slip_o(frame_slip)
  );

  adc_sample_buffer #(
    .NUM_LANES(NUM_LANES),
    .READ_DELAY(READ_DELAY),
    .BUF_DEPTH(BUF_DEPTH)
  ) adc_sample_buffer_inst (
    .fclk_int(fclk_int),
    .rst(rst),
    .sync_i(sync_i),
    .buffer_reset_i(buffer_reset),
    .clear_counts_i(clear_counts),
    .lane_words_i(lane_words),
    .word_valid_i(word_valid),
    .samples_o(samples_o),
    .armed_o(armed),
    .words_written_o(words_written)
  );

  adc_rx_regs #(
    .NUM_LANES(NUM_LANES)
  ) adc_rx_regs_inst (
    .fclk_int(fclk_int),
    .rst(rst),
    .bus_req_i(bus_req_i),
    .frame_err_i(frame_err),
    .words_written_i(words_written),
    .frame_slip_i(frame_slip),
    .armed_i(armed),
    .bus_rsp_o(bus_rsp_o),
    .slip_lanes_o(slip_lanes),
    .slip_frame_o(slip_frame),
    .clear_counts_o(clear_counts),
    .buffer_reset_o(buffer_reset)
  );

endmodule

// File: tb_adc_rx.sv
`timescale 1ns/1ps

module tb_adc_rx;

  // Must match the DUT defaults
  localparam int NL = 4;
  localparam int RD = 3;
  localparam int SW = adc_rx_pkg::SAMPLE_W;
  localparam int SLOTS = 20;
  // Slot runs plus bus operations, each with a bounded wait
  localparam int STIM_CYCLES = 12 * SLOTS * adc_rx_pkg::SLOT_CYCLES + 40 * 24;

  typedef logic [NL-1:0][SW-1:0] set_t;

  // Reference words and, once aligned, the samples that were sent
  typedef struct packed {
    set_t ref_set;
    set_t sent_set;
  } exp_t;

  logic fclk_int = 1'b0;
  logic rst;
  logic sync;
  adc_rx_pkg::lane_slice_t [NL-1:0] data_slice;
  adc_rx_pkg::lane_slice_t frame_slice;
  adc_rx_pkg::bus_req_t bus_req;
  adc_rx_pkg::sample_set_t samples;
  adc_rx_pkg::bus_rsp_t bus_rsp;

  // Serializer state, frame lane at index NL
  int edge_cnt = 0;
  int drv_idx = 0;
  int add_bits [NL+1];
  logic [1:0] bitq [NL+1][$];
  logic [SW-1:0] sentq [NL][$];
  set_t last_sent;

  // Model state
  logic [19:0] m_hist [NL+1];
  logic [3:0]  m_slip [NL+1];
  int   m_phase;
  bit   m_armed;
  bit   wv_pend;
  bit   fe_pend;
  bit   sync_q_m;
  int   m_words;
  int   m_ferr;
  bit   aligned;
  exp_t word_hold;
  exp_t dq[$];
  exp_t cq[$];
  bit   pend_slip [NL+1];
  bit   pend_cc;
  bit   pend_br;

  int err_data;
  int err_bus;
  int err_other;
  int off [NL];
  int fk;
  int ferr_a;
  logic [31:0] mask;

  adc_rx_top adc_rx_top_inst (
    .fclk_int(fclk_int),
    .rst(rst),
    .data_slice_i(data_slice),
    .frame_slice_i(frame_slice),
    .sync_i(sync),
    .bus_req_i(bus_req),
    .samples_o(samples),
    .bus_rsp_o(bus_rsp)
  );

  always #4 fclk_int = ~fclk_int;

  // Expected word, bit i taken from history bit i+slip
  function automatic logic [SW-1:0] ref_word(input logic [19:0] h, input int s);
    logic [SW-1:0] w;
    for (int i = 0; i < SW; i++) begin
      w[i] = h[i + s];
    end
    return w;
  endfunction

  function automatic logic [31:0] reg_model(input logic [1:0] adr);
    case (adr)
      2'd1: return 32'(m_ferr);
      2'd2: return 32'(m_words);
      2'd3: return {23'd0, m_armed, 4'd0, m_slip[NL]};
      default: return 32'd0;
    endcase
  endfunction

  // Reset release and serializer, MSB first, new word when index is 0
  always @(posedge fclk_int) begin
    logic [SW-1:0] smp;
    logic [1:0] e_rise;
    logic [1:0] e_fall;
    #1;
    edge_cnt++;
    if (edge_cnt >= 5) begin
      rst = 1'b0;
      for (int ch = 0; ch <= NL; ch++) begin
        if (drv_idx == 0) begin
          // Offset k pads 10-k bits, so a word ends k bits before the slot
          if (add_bits[ch] != 0) begin
            repeat (SW - add_bits[ch]) bitq[ch].push_back(2'b00);
          end
          add_bits[ch] = 0;
          smp = (ch == NL) ? adc_rx_pkg::FRAME_PATTERN : SW'($urandom);
          if (ch < NL) begin
            sentq[ch].push_back(smp);
          end
          // Bit 1 tags the last bit of a data sample
          for (int b = SW - 1; b >= 0; b--) begin
            bitq[ch].push_back({(b == 0) && (ch < NL), smp[b]});
          end
        end
        e_rise = bitq[ch].pop_front();
        e_fall = bitq[ch].pop_front();
        if (e_rise[1] || e_fall[1]) begin
          last_sent[ch] = sentq[ch].pop_front();
        end
        if (ch == NL) begin
          frame_slice.rise = e_rise[0];
          frame_slice.fall = e_fall[0];
        end else begin
          data_slice[ch].rise = e_rise[0];
          data_slice[ch].fall = e_fall[0];
        end
      end
      drv_idx = (drv_idx == 4) ? 0 : drv_idx + 1;
    end
  end

  // Reference model of slots, buffer delay and counters
  always @(posedge fclk_int) begin
    bit took_ack;
    bit br;
    took_ack = bus_rsp.ack;
    for (int ch = 0; ch <= NL; ch++) begin
      if (ch == NL) begin
        m_hist[ch] = {m_hist[ch][17:0], frame_slice.rise, frame_slice.fall};
      end else begin
        m_hist[ch] = {m_hist[ch][17:0], data_slice[ch].rise, data_slice[ch].fall};
      end
    end
    if (rst) begin
      m_phase = 0;
      m_armed = 0;
      wv_pend = 0;
      fe_pend = 0;
      sync_q_m = 0;
      m_words = 0;
      m_ferr = 0;
      for (int ch = 0; ch <= NL; ch++) begin
        m_slip[ch] = '0;
      end
    end else begin
      br = took_ack && pend_br;
      if (m_armed && wv_pend && !br) begin
        dq.push_back(word_hold);
        // Read starts once RD sets wait
        if (dq.size() > RD) begin
          cq.push_back(dq.pop_front());
        end
        m_words++;
      end
      if (fe_pend) begin
        m_ferr++;
      end
      if (took_ack && pend_cc) begin
        m_words = 0;
        m_ferr = 0;
      end
      if (br) begin
        m_armed = 0;
        dq.delete();
      end else if (sync && !sync_q_m) begin
        m_armed = 1;
      end
      sync_q_m = sync;
      wv_pend = (m_phase == 4);
      fe_pend = 0;
      if (m_phase == 4) begin
        for (int l = 0; l < NL; l++) begin
          word_hold.ref_set[l] = ref_word(m_hist[l], m_slip[l]);
          // Aligned lanes give back the last sample sent
          word_hold.sent_set[l] = aligned ? last_sent[l] : word_hold.ref_set[l];
        end
        fe_pend = (ref_word(m_hist[NL], m_slip[NL]) != adc_rx_pkg::FRAME_PATTERN);
      end
      // Slips take effect after this slot's extraction
      if (took_ack) begin
        for (int ch = 0; ch <= NL; ch++) begin
          if (pend_slip[ch]) begin
            m_slip[ch] = (m_slip[ch] == 4'd9) ? 4'd0 : m_slip[ch] + 4'd1;
          end
          pend_slip[ch] = 0;
        end
        pend_cc = 0;
        pend_br = 0;
      end
      m_phase = (m_phase == 4) ? 0 : m_phase + 1;
    end
  end

  // Output checker
  always @(posedge fclk_int) begin
    exp_t exp;
    if (!rst && samples.valid) begin
      if (cq.size() == 0) begin
        err_other++;
        $display("Valid output appeared with no sample set expected at %0t", $time);
      end else begin
        exp = cq.pop_front();
        for (int l = 0; l < NL; l++) begin
          if (samples.data[l] != exp.ref_set[l]) begin
            err_data++;
            $display("Error samples_o lane %0d: expected %h, got %h",
                     l, exp.ref_set[l], samples.data[l]);
          end else if (samples.data[l] != exp.sent_set[l]) begin
            err_data++;
            $display("Error samples_o lane %0d: sent %h, got %h",
                     l, exp.sent_set[l], samples.data[l]);
          end
        end
        // Lanes above NL carry nothing
        if (samples.data[adc_rx_pkg::MAX_LANES-1:NL] != '0) begin
          err_data++;
          $display("Error samples_o unused lanes: expected 0, got %h",
                   samples.data[adc_rx_pkg::MAX_LANES-1:NL]);
        end
      end
    end
  end

  task automatic next_cycle();
    @(posedge fclk_int);
    #1;
  endtask

  task automatic run_slots(input int n);
    repeat (n * adc_rx_pkg::SLOT_CYCLES) next_cycle();
  endtask

  // Returns just after a slot edge
  task automatic wait_slot();
    do begin
      next_cycle();
    end while (m_phase != 0);
  endtask

  task automatic sync_pulse();
    sync = 1'b1;
    next_cycle();
    next_cycle();
    sync = 1'b0;
  endtask

  task automatic bus_access(input bit we, input logic [1:0] adr, input logic [31:0] dat,
                            input bit exp_err);
    logic [31:0] exp_dat;
    int wait_cnt;
    // Previous response must be gone first
    next_cycle();
    exp_dat = reg_model(adr);
    if (we && !exp_err) begin
      if (adr == 2'd0) begin
        for (int l = 0; l < NL; l++) begin
          pend_slip[l] = dat[l];
        end
        pend_slip[NL] = dat[8];
      end else begin
        pend_cc = dat[0];
        pend_br = dat[1];
      end
    end
    bus_req.cyc = 1'b1;
    bus_req.stb = 1'b1;
    bus_req.we = we;
    bus_req.adr = adr;
    bus_req.dat = dat;
    wait_cnt = 0;
    do begin
      next_cycle();
      wait_cnt++;
    end while (!bus_rsp.ack && !bus_rsp.err && wait_cnt < 16);
    bus_req.cyc = 1'b0;
    bus_req.stb = 1'b0;
    if (!bus_rsp.ack && !bus_rsp.err) begin
      err_bus++;
      $display("No bus response for address %0d within 16 cycles", adr);
    end else if (bus_rsp.err != exp_err || bus_rsp.ack == exp_err) begin
      err_bus++;
      $display("Error bus_rsp_o addr %0d: expected err %h, got ack %h err %h",
               adr, exp_err, bus_rsp.ack, bus_rsp.err);
    end else if (!we && !exp_err && bus_rsp.dat != exp_dat) begin
      err_bus++;
      $display("Error bus_rsp_o.dat addr %0d: expected %h, got %h", adr, exp_dat, bus_rsp.dat);
    end
  endtask

  initial begin
    rst = 1'b1;
    sync = 1'b0;
    bus_req = '0;
    data_slice = '0;
    frame_slice = '0;
    err_data = 0;
    err_bus = 0;
    err_other = 0;
    pend_cc = 0;
    pend_br = 0;
    aligned = 1'b1;
    for (int ch = 0; ch <= NL; ch++) begin
      add_bits[ch] = 0;
      pend_slip[ch] = 0;
      m_hist[ch] = '0;
      m_slip[ch] = '0;
    end
    void'($urandom(11115));
    repeat (6) next_cycle();
    // Aligned lanes, nothing valid before sync
    run_slots(4);
    sync_pulse();
    run_slots(SLOTS);
    // Random lane offsets, then slip each lane into place
    aligned = 1'b0;
    for (int l = 0; l < NL; l++) begin
      off[l] = $urandom_range(9, 1);
      add_bits[l] = off[l];
    end
    run_slots(3);
    for (int s = 1; s <= 9; s++) begin
      mask = '0;
      for (int l = 0; l < NL; l++) begin
        if (off[l] >= s) begin
          mask[l] = 1'b1;
        end
      end
      if (mask != 0) begin
        bus_access(1'b1, 2'd0, mask, 1'b0);
      end
    end
    // Last slip is in place from the next slot on
    wait_slot();
    aligned = 1'b1;
    run_slots(SLOTS);
    // Frame lane offset, error count, then frame slips
    fk = $urandom_range(9, 1);
    add_bits[NL] = fk;
    run_slots(4);
    bus_access(1'b0, 2'd1, 32'd0, 1'b0);
    repeat (fk) bus_access(1'b1, 2'd0, 32'h100, 1'b0);
    run_slots(2);
    bus_access(1'b0, 2'd1, 32'd0, 1'b0);
    ferr_a = m_ferr;
    run_slots(SLOTS / 2);
    bus_access(1'b0, 2'd1, 32'd0, 1'b0);
    if (m_ferr != ferr_a) begin
      err_other++;
      $display("Frame errors kept counting after the frame lane was aligned");
    end
    bus_access(1'b0, 2'd3, 32'd0, 1'b0);
    // Word count, then clear just after a slot
    bus_access(1'b0, 2'd2, 32'd0, 1'b0);
    wait_slot();
    bus_access(1'b1, 2'd1, 32'h1, 1'b0);
    bus_access(1'b0, 2'd1, 32'd0, 1'b0);
    bus_access(1'b0, 2'd2, 32'd0, 1'b0);
    // Buffer reset drops armed, new sync restarts
    bus_access(1'b1, 2'd1, 32'h2, 1'b0);
    bus_access(1'b0, 2'd3, 32'd0, 1'b0);
    run_slots(SLOTS / 2);
    sync_pulse();
    run_slots(SLOTS);
    // Illegal accesses get err and change nothing
    bus_access(1'b0, 2'd0, 32'd0, 1'b1);
    bus_access(1'b1, 2'd2, 32'hffff_ffff, 1'b1);
    bus_access(1'b0, 2'd1, 32'd0, 1'b0);
    bus_access(1'b0, 2'd2, 32'd0, 1'b0);
    run_slots(2);
    $display("Errors: data %0d, bus %0d, other %0d", err_data, err_bus, err_other);
    if (err_data + err_bus + err_other == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (STIM_CYCLES + 200) @(posedge fclk_int);
    $display("Timeout: the run did not finish within %0d cycles", STIM_CYCLES + 200);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: verilog.f
adc_rx_pkg.sv
adc_lane_deser.sv
adc_sample_buffer.sv
adc_rx_regs.sv
adc_rx_top.sv
tb_adc_rx.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_adc_rx \
  -f verilog.f -o tb_adc_rx

out=$(./obj_dir/tb_adc_rx)
echo "$out"

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
  exit 0
fi
exit 1
